//--- src/bicubic_pkg.sv
// bicubic line buffer shared types for pixels, window columns and the scan state
`default_nettype none

package bicubic_pkg;

    // RGB888
    localparam int PIXEL_W = 24;

    // the window is TAPS rows by TAPS columns
    localparam int TAPS = 4;

    // four banks feed the window while the fifth takes the incoming row
    localparam int NUM_BANKS = 5;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // one window column, p0 is the top tap row (r-1)
    typedef struct packed {
        pixel_t p0;
        pixel_t p1;
        pixel_t p2;
        pixel_t p3;
    } column_t;

    // c0 is the leftmost column (c-1), c3 the rightmost (c+2)
    typedef struct packed {
        column_t c0;
        column_t c1;
        column_t c2;
        column_t c3;
    } window_t;

    typedef enum logic [1:0] {
        SCAN_FILL,
        SCAN_EMIT,
        SCAN_DONE
    } scan_state_e;

endpackage

`default_nettype wire

//--- src/row_bank.sv
// row bank holding one image row, synchronous write and one-cycle registered read
`timescale 1ns/1ps
`default_nettype none

module row_bank #(
    parameter int DEPTH = 8,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  wire                      clk,
    input  wire                      wr_en,
    input  wire [ADDR_W-1:0]         wr_addr,
    input  wire bicubic_pkg::pixel_t wr_data,
    input  wire                      rd_en,
    input  wire [ADDR_W-1:0]         rd_addr,
    output bicubic_pkg::pixel_t      rd_data
);
    import bicubic_pkg::*;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // data for rd_addr shows up on the next clock
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- src/row_ring.sv
// row ring of five banks, rotates the write bank and muxes clamped tap rows on read
`timescale 1ns/1ps
`default_nettype none

module row_ring #(
    parameter int IMG_WIDTH = 8,
    parameter int IMG_HEIGHT = 6,
    localparam int COL_W = $clog2(IMG_WIDTH),
    localparam int ROW_W = $clog2(IMG_HEIGHT + 1)
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wr_en,
    input  wire [COL_W-1:0]          wr_col,
    input  wire bicubic_pkg::pixel_t wr_data,
    input  wire                      rd_en,
    input  wire [COL_W-1:0]          rd_col,
    input  wire [ROW_W-1:0]          rd_row,
    output bicubic_pkg::column_t     rd_column,
    output logic                     rd_column_valid
);
    import bicubic_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic [ROW_W-1:0]  wr_row;
    logic [BANK_W-1:0] wr_bank;
    logic [BANK_W-1:0] tap_bank [TAPS];
    logic [BANK_W-1:0] tap_bank_q [TAPS];
    pixel_t            bank_rd [NUM_BANKS];

    function automatic int clamp_row(input int row);
        if (row < 0) begin
            return 0;
        end
        if (row > IMG_HEIGHT - 1) begin
            return IMG_HEIGHT - 1;
        end
        return row;
    endfunction

    function automatic logic [BANK_W-1:0] bank_of(input int row);
        return BANK_W'(row % NUM_BANKS);
    endfunction

    // completed rows, one step per last pixel of a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_row <= '0;
        end else if (wr_en && wr_col == COL_W'(IMG_WIDTH - 1)) begin
            wr_row <= wr_row + 1'b1;
        end
    end

    assign wr_bank = bank_of(int'(wr_row));

    // taps r-1..r+2, edge rows repeat past the image border
    always_comb begin
        for (int t = 0; t < TAPS; t++) begin
            tap_bank[t] = bank_of(clamp_row(int'(rd_row) + t - 1));
        end
    end

    // bank selection travels with the read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            tap_bank_q <= tap_bank;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_column_valid <= 1'b0;
        end else begin
            rd_column_valid <= rd_en;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        row_bank #(
            .DEPTH(IMG_WIDTH)
        ) u_row_bank (
            .clk(clk),
            .wr_en(wr_en && wr_bank == BANK_W'(b)),
            .wr_addr(wr_col),
            .wr_data(wr_data),
            .rd_en(rd_en),
            .rd_addr(rd_col),
            .rd_data(bank_rd[b])
        );
    end

    always_comb begin
        rd_column.p0 = bank_rd[tap_bank_q[0]];
        rd_column.p1 = bank_rd[tap_bank_q[1]];
        rd_column.p2 = bank_rd[tap_bank_q[2]];
        rd_column.p3 = bank_rd[tap_bank_q[3]];
    end

endmodule

`default_nettype wire

//--- src/scan_ctrl.sv
// scan controller for write counters, output row sequencing and column read order
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl #(
    parameter int IMG_WIDTH = 8,
    parameter int IMG_HEIGHT = 6,
    localparam int COL_W = $clog2(IMG_WIDTH),
    localparam int ROW_W = $clog2(IMG_HEIGHT + 1)
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    output logic             in_ready,
    output logic             wr_en,
    output logic [COL_W-1:0] wr_col,
    output logic             rd_en,
    output logic [COL_W-1:0] rd_col,
    output logic [ROW_W-1:0] rd_row,
    output logic             row_start,
    input  wire              slot_free,
    input  wire              win_accepted
);
    import bicubic_pkg::*;

    // each output row reads W+3 columns, index 0..W+2
    localparam int IDX_W = $clog2(IMG_WIDTH + 4);
    localparam int FILL_ROWS = (IMG_HEIGHT < 3) ? IMG_HEIGHT : 3;

    scan_state_e      state;
    logic [ROW_W-1:0] wr_row;
    logic [ROW_W-1:0] out_row;
    logic [IDX_W-1:0] rd_idx;
    logic [COL_W-1:0] win_cnt;
    logic             in_fire;
    logic             wr_row_end;
    logic             rows_ready;
    logic             reads_left;
    logic             last_win;
    int               need_rows;

    assign in_fire = in_valid && in_ready;
    assign wr_en = in_fire;
    assign wr_row_end = (wr_col == COL_W'(IMG_WIDTH - 1));

    // writer may run at most four rows ahead of the output row
    assign in_ready = (state != SCAN_DONE)
                   && (int'(wr_row) < IMG_HEIGHT)
                   && (int'(wr_row) <= int'(out_row) + 3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_col <= '0;
            wr_row <= '0;
        end else if (in_fire) begin
            if (wr_row_end) begin
                wr_col <= '0;
                wr_row <= wr_row + 1'b1;
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    // rows 0..min(r+2, H-1) have to be complete
    always_comb begin
        if (int'(out_row) + 3 < IMG_HEIGHT) begin
            need_rows = int'(out_row) + 3;
        end else begin
            need_rows = IMG_HEIGHT;
        end
    end

    assign rows_ready = (int'(wr_row) >= need_rows);
    assign reads_left = (int'(rd_idx) < IMG_WIDTH + 3);

    // one column in flight at most, slot_free covers the returning read
    assign rd_en = (state == SCAN_EMIT) && rows_ready && reads_left && slot_free;
    assign row_start = rd_en && (rd_idx == '0);
    assign rd_row = out_row;

    // column sequence clamp(k-1) repeats the left and right edge columns
    always_comb begin
        if (rd_idx == '0) begin
            rd_col = '0;
        end else if (int'(rd_idx) - 1 >= IMG_WIDTH - 1) begin
            rd_col = COL_W'(IMG_WIDTH - 1);
        end else begin
            rd_col = COL_W'(rd_idx - 1'b1);
        end
    end

    assign last_win = win_accepted && (int'(win_cnt) == IMG_WIDTH - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SCAN_FILL;
            out_row <= '0;
            rd_idx  <= '0;
            win_cnt <= '0;
        end else begin
            case (state)
                SCAN_FILL: begin
                    if (int'(wr_row) >= FILL_ROWS) begin
                        state <= SCAN_EMIT;
                    end
                end
                SCAN_EMIT: begin
                    if (rd_en) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                    if (last_win) begin
                        win_cnt <= '0;
                    end else if (win_accepted) begin
                        win_cnt <= win_cnt + 1'b1;
                    end
                    // W-th window closes the row
                    if (last_win) begin
                        rd_idx <= '0;
                        if (int'(out_row) == IMG_HEIGHT - 1) begin
                            state <= SCAN_DONE;
                        end else begin
                            out_row <= out_row + 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/window_shift.sv
// window builder, a one-column slot feeding a 4-column shift register with handshake
`timescale 1ns/1ps
`default_nettype none

module window_shift (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire bicubic_pkg::column_t rd_column,
    input  wire                       rd_column_valid,
    input  wire                       row_start,
    output logic                      slot_free,
    output bicubic_pkg::window_t      out_window,
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic                      win_accepted
);
    import bicubic_pkg::*;

    localparam int FILL_W = $clog2(TAPS + 1);

    column_t           slot_col;
    logic              slot_valid;
    logic              slot_first;
    logic              first_q;
    logic              stalled;
    logic              shift_en;
    logic [FILL_W-1:0] fill_cnt;
    logic [FILL_W-1:0] fill_nxt;

    assign stalled = out_valid && !out_ready;
    assign shift_en = slot_valid && !stalled;
    assign win_accepted = out_valid && out_ready;

    // next read allowed only when its column will find the slot empty
    assign slot_free = !rd_column_valid && (!slot_valid || shift_en);

    // row_start comes with the read, the column returns a cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_q <= 1'b0;
        end else begin
            first_q <= row_start;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            slot_first <= 1'b0;
        end else if (rd_column_valid) begin
            slot_valid <= 1'b1;
            slot_first <= first_q;
        end else if (shift_en) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_column_valid) begin
            slot_col <= rd_column;
        end
    end

    // shifts into the current row, saturating at a full window
    always_comb begin
        if (slot_first) begin
            fill_nxt = FILL_W'(1);
        end else if (fill_cnt == FILL_W'(TAPS)) begin
            fill_nxt = fill_cnt;
        end else begin
            fill_nxt = fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            out_valid <= 1'b0;
        end else if (shift_en) begin
            fill_cnt  <= fill_nxt;
            out_valid <= (fill_nxt == FILL_W'(TAPS));
        end else if (win_accepted) begin
            out_valid <= 1'b0;
        end
    end

    // new column enters on the right, window holds while stalled
    always_ff @(posedge clk) begin
        if (shift_en) begin
            out_window <= {out_window.c1, out_window.c2, out_window.c3, slot_col};
        end
    end

endmodule

`default_nettype wire

//--- src/line_buffer_top.sv
// bicubic line buffer top, streams pixels in and 4x4 edge-clamped windows out
`timescale 1ns/1ps
`default_nettype none

module line_buffer_top #(
    parameter int IMG_WIDTH = 8,
    parameter int IMG_HEIGHT = 6
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire bicubic_pkg::pixel_t  in_data,
    input  wire                       in_valid,
    output wire                       in_ready,
    output wire bicubic_pkg::window_t out_window,
    output wire                       out_valid,
    input  wire                       out_ready
);
    import bicubic_pkg::*;

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT + 1);

    logic             wr_en;
    logic [COL_W-1:0] wr_col;
    logic             rd_en;
    logic [COL_W-1:0] rd_col;
    logic [ROW_W-1:0] rd_row;
    logic             row_start;
    logic             slot_free;
    logic             win_accepted;
    column_t          rd_column;
    logic             rd_column_valid;

    scan_ctrl #(
        .IMG_WIDTH(IMG_WIDTH),
        .IMG_HEIGHT(IMG_HEIGHT)
    ) u_scan_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .wr_en(wr_en),
        .wr_col(wr_col),
        .rd_en(rd_en),
        .rd_col(rd_col),
        .rd_row(rd_row),
        .row_start(row_start),
        .slot_free(slot_free),
        .win_accepted(win_accepted)
    );

    row_ring #(
        .IMG_WIDTH(IMG_WIDTH),
        .IMG_HEIGHT(IMG_HEIGHT)
    ) u_row_ring (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .wr_col(wr_col),
        .wr_data(in_data),
        .rd_en(rd_en),
        .rd_col(rd_col),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_column_valid(rd_column_valid)
    );

    window_shift u_window_shift (
        .clk(clk),
        .rst_n(rst_n),
        .rd_column(rd_column),
        .rd_column_valid(rd_column_valid),
        .row_start(row_start),
        .slot_free(slot_free),
        .out_window(out_window),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .win_accepted(win_accepted)
    );

endmodule

`default_nettype wire

//--- tb/tb_line_buffer.sv
// testbench for the bicubic line buffer, random image with input gaps and output stalls
`timescale 1ns/1ps
`default_nettype none

module tb_line_buffer;
    import bicubic_pkg::*;

    localparam int W = 8;
    localparam int H = 6;
    localparam int NPIX = W * H;
    localparam int TIMEOUT = 40 * W * H + 200;

    logic    clk;
    logic    rst_n;
    pixel_t  in_data;
    logic    in_valid;
    logic    in_ready;
    window_t out_window;
    logic    out_valid;
    logic    out_ready;

    pixel_t  image [NPIX];
    int      send_idx;
    int      in_cnt;
    int      win_cnt;
    int      cycles;
    int      mismatch_errs;
    int      other_errs;
    logic    hold_check;
    logic    done_seen;
    window_t held_window;
    window_t exp_window;

    line_buffer_top #(
        .IMG_WIDTH(W),
        .IMG_HEIGHT(H)
    ) dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_window(out_window),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    // out-of-image coordinates repeat the nearest edge pixel
    function automatic pixel_t pixel_at(input int r, input int c);
        int rr;
        int cc;
        rr = (r < 0) ? 0 : ((r > H - 1) ? H - 1 : r);
        cc = (c < 0) ? 0 : ((c > W - 1) ? W - 1 : c);
        return image[rr * W + cc];
    endfunction

    // rows r-1..r+2 top to bottom, columns c-1..c+2 left to right
    function automatic window_t model_window(input int r, input int c);
        column_t col [TAPS];
        for (int j = 0; j < TAPS; j++) begin
            col[j] = {pixel_at(r - 1, c + j - 1), pixel_at(r, c + j - 1),
                      pixel_at(r + 1, c + j - 1), pixel_at(r + 2, c + j - 1)};
        end
        return {col[0], col[1], col[2], col[3]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // in_valid holds until its transfer, then may take a gap
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid && in_ready) begin
                send_idx++;
            end
            if (!in_valid || in_ready) begin
                if (send_idx >= NPIX) begin
                    // keep offering data past the frame end
                    in_valid <= 1'b1;
                    in_data  <= pixel_t'($urandom);
                end else if ($urandom % 4 != 0) begin
                    in_valid <= 1'b1;
                    in_data  <= image[send_idx];
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= ($urandom % 3) != 0;
        end
    end

    // ends the run if the frame never completes
    initial begin
        wait (rst_n === 1'b1);
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout with %0d of %0d windows after %0d cycles",
                 win_cnt, NPIX, cycles);
        $display("Test failed");
        $finish;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (done_seen) begin
                assert (out_valid === 1'b0) else begin
                    mismatch_errs++;
                    $display("MISMATCH out_valid after frame: expected 0 got %0h", out_valid);
                end
                assert (in_ready === 1'b0) else begin
                    mismatch_errs++;
                    $display("MISMATCH in_ready after frame: expected 0 got %0h", in_ready);
                end
            end
            if (hold_check) begin
                assert (out_valid === 1'b1) else begin
                    mismatch_errs++;
                    $display("MISMATCH out_valid under stall: expected 1 got %0h", out_valid);
                end
                assert (out_window === held_window) else begin
                    mismatch_errs++;
                    $display("MISMATCH out_window under stall: expected %h got %h",
                             held_window, out_window);
                end
            end
            hold_check  = out_valid && !out_ready;
            held_window = out_window;
            if (in_valid && in_ready) begin
                assert (in_cnt < NPIX) else begin
                    other_errs++;
                    $display("input pixel accepted after the whole frame was written");
                end
                assert (in_cnt < (win_cnt / W + 4) * W) else begin
                    other_errs++;
                    $display("input accepted more than four rows ahead of the output");
                end
                in_cnt++;
            end
            if (out_valid && out_ready) begin
                assert (win_cnt < NPIX) else begin
                    other_errs++;
                    $display("window accepted after the last window of the frame");
                end
                exp_window = model_window(win_cnt / W, win_cnt % W);
                assert (out_window === exp_window) else begin
                    mismatch_errs++;
                    $display("MISMATCH out_window at (%0d,%0d): expected %h got %h",
                             win_cnt / W, win_cnt % W, exp_window, out_window);
                end
                win_cnt++;
                if (win_cnt == NPIX) begin
                    done_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h5c22fccb));
        for (int i = 0; i < NPIX; i++) begin
            image[i] = pixel_t'($urandom);
        end
        send_idx = 0;
        in_cnt = 0;
        win_cnt = 0;
        cycles = 0;
        mismatch_errs = 0;
        other_errs = 0;
        hold_check = 1'b0;
        done_seen = 1'b0;
        rst_n <= 1'b0;
        in_valid <= 1'b0;
        in_data <= '0;
        out_ready <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (in_ready === 1'b1) else begin
            mismatch_errs++;
            $display("MISMATCH in_ready after reset: expected 1 got %0h", in_ready);
        end
        assert (out_valid === 1'b0) else begin
            mismatch_errs++;
            $display("MISMATCH out_valid after reset: expected 0 got %0h", out_valid);
        end
        wait (win_cnt == NPIX);
        // idle tail so the post-frame checks see a few edges
        repeat (20) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
src/bicubic_pkg.sv
src/row_bank.sv
src/row_ring.sv
src/scan_ctrl.sv
src/window_shift.sv
src/line_buffer_top.sv
tb/tb_line_buffer.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_line_buffer -f all.f \
    && ./obj_dir/Vtb_line_buffer > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass line in log"; exit 1; }
echo "simulation passed"
